// File: hw/core_pkg.sv
// Core data width and memory operation codes
package core_pkg;

    // Width of data and addresses
    localparam int XLEN = 32;

    // Loads keep their funct3 codes
    // Stores take the three codes that loads leave free
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        SB  = 3'b011,   // Store byte
        LBU = 3'b100,
        LHU = 3'b101,
        SH  = 3'b110,   // Store halfword
        SW  = 3'b111    // Store word
    } mem_op_e;

endpackage

// File: hw/mem_pkg.sv
// Data memory geometry and the byte/halfword view of a memory word
package mem_pkg;

    localparam int BYTE_W = 8;
    localparam int HALF_W = 2 * BYTE_W;

    // Byte offset bits inside a word
    localparam int ADDR_LSB = 2;

    localparam int BYTES_PER_WORD  = 1 << ADDR_LSB;
    localparam int HALVES_PER_WORD = BYTES_PER_WORD / 2;

    // One memory word, decoded as byte lanes or as halfword lanes
    // Lane 0 sits at the least significant end, as in a little endian core
    typedef union packed {
        logic [BYTES_PER_WORD-1:0][BYTE_W-1:0]  bytes;
        logic [HALVES_PER_WORD-1:0][HALF_W-1:0] halves;
    } mem_word_u;

endpackage

// File: hw/dmem_if.sv
// Request and response signals between the load/store unit and the data memory
interface dmem_if;

    logic                                sel;    // Request active, fields held while high
    logic [core_pkg::XLEN-1:0]           addr;   // Word aligned
    logic [core_pkg::XLEN-1:0]           wdata;  // Already shifted into its lanes
    logic [mem_pkg::BYTES_PER_WORD-1:0]  mask;
    logic                                wen;
    logic [core_pkg::XLEN-1:0]           rdata;  // Registered read, one cycle behind addr
    logic                                stall;

    // Requester side
    modport lsu (
        output sel,
        output addr,
        output wdata,
        output mask,
        output wen,
        input  rdata,
        input  stall
    );

    // Memory side
    modport mem (
        input  sel,
        input  addr,
        input  wdata,
        input  mask,
        input  wen,
        output rdata,
        output stall
    );

endinterface

// File: hw/load_store_unit.sv
// Load/store unit with store lane placement and load extraction with extension
module load_store_unit (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      start_i,
    input  core_pkg::mem_op_e         op_i,
    input  logic [core_pkg::XLEN-1:0] addr_i,
    input  logic [core_pkg::XLEN-1:0] store_data_i,
    output logic [core_pkg::XLEN-1:0] result_o,
    output logic                      done_o,
    dmem_if.lsu                       mem
);
    logic [mem_pkg::ADDR_LSB-1:0]       offset;
    logic                               is_store;
    mem_pkg::mem_word_u                 st_word;
    logic [mem_pkg::BYTES_PER_WORD-1:0] st_mask;

    // Operation and offset of the previous cycle, in step with the registered read
    core_pkg::mem_op_e                  op_q;
    logic [mem_pkg::ADDR_LSB-1:0]       offset_q;

    mem_pkg::mem_word_u                 ld_word;
    logic [mem_pkg::BYTE_W-1:0]         ld_byte;
    logic [mem_pkg::HALF_W-1:0]         ld_half;

    assign offset   = addr_i[mem_pkg::ADDR_LSB-1:0];
    assign is_store = (op_i == core_pkg::SB) || (op_i == core_pkg::SH) ||
                      (op_i == core_pkg::SW);

    assign mem.sel   = start_i;
    assign mem.wen   = start_i && is_store;
    assign mem.addr  = {addr_i[core_pkg::XLEN-1:mem_pkg::ADDR_LSB], {mem_pkg::ADDR_LSB{1'b0}}};
    assign mem.wdata = st_word;
    assign mem.mask  = st_mask;

    assign done_o = start_i && !mem.stall;

    always_comb begin
        st_word = '0;
        st_mask = '1; // Loads and word stores cover the whole word
        case (op_i)
            core_pkg::SB: begin
                st_word.bytes[offset] = store_data_i[mem_pkg::BYTE_W-1:0];
                st_mask               = '0;
                st_mask[offset]       = 1'b1;
            end
            core_pkg::SH: begin
                // Halfword addresses are even, so the top offset bit picks the half
                st_word.halves[offset[mem_pkg::ADDR_LSB-1]] = store_data_i[mem_pkg::HALF_W-1:0];
                st_mask                                     = '0;
                st_mask[{offset[mem_pkg::ADDR_LSB-1], 1'b0} +: 2] = 2'b11;
            end
            core_pkg::SW: begin
                st_word = store_data_i;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            op_q     <= core_pkg::LW;
            offset_q <= '0;
        end else begin
            op_q     <= op_i;
            offset_q <= offset;
        end
    end

    always_comb begin
        ld_word = mem.rdata;
        ld_byte = ld_word.bytes[offset_q];
        ld_half = ld_word.halves[offset_q[mem_pkg::ADDR_LSB-1]];
        case (op_q)
            core_pkg::LB:  result_o = {{(core_pkg::XLEN-mem_pkg::BYTE_W){ld_byte[7]}}, ld_byte};
            core_pkg::LBU: result_o = {{(core_pkg::XLEN-mem_pkg::BYTE_W){1'b0}}, ld_byte};
            core_pkg::LH:  result_o = {{(core_pkg::XLEN-mem_pkg::HALF_W){ld_half[15]}}, ld_half};
            core_pkg::LHU: result_o = {{(core_pkg::XLEN-mem_pkg::HALF_W){1'b0}}, ld_half};
            default:       result_o = ld_word; // LW, and stores where the result is ignored
        endcase
    end

endmodule

// File: hw/data_mem.sv
// Word-addressed data memory with byte-masked writes, registered read and wait counter
module data_mem #(
    parameter int WAIT_CYCLES = 2,
    parameter int DEPTH_WORDS = 256
) (
    input  logic clk_i,
    input  logic rst_i,
    dmem_if.mem  bus
);
    localparam int IDX_W = $clog2(DEPTH_WORDS);
    localparam int CNT_W = $clog2(WAIT_CYCLES + 1);

    mem_pkg::mem_word_u        mem_q [DEPTH_WORDS];
    mem_pkg::mem_word_u        rdata_q;
    logic [IDX_W-1:0]          idx;
    logic [CNT_W-1:0]          wait_cnt_q;
    logic                      access_done;

    assign idx = bus.addr[mem_pkg::ADDR_LSB +: IDX_W];

    // Held high for the first WAIT_CYCLES cycles of every access
    assign bus.stall   = bus.sel && (wait_cnt_q < CNT_W'(WAIT_CYCLES));
    assign access_done = bus.sel && !bus.stall;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wait_cnt_q <= '0;
        end else if (!bus.sel || access_done) begin
            wait_cnt_q <= '0; // Back to back requests start counting again
        end else begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (access_done && bus.wen) begin
            for (int i = 0; i < mem_pkg::BYTES_PER_WORD; i++) begin
                if (bus.mask[i]) begin
                    mem_q[idx].bytes[i] <= bus.wdata[i*mem_pkg::BYTE_W +: mem_pkg::BYTE_W];
                end
            end
        end
        rdata_q <= mem_q[idx]; // The held address makes this valid once stall falls
    end

    assign bus.rdata = rdata_q;

endmodule

// File: hw/mem_stage_top.sv
// Memory stage top level joining the load/store unit and the data memory
module mem_stage_top #(
    parameter int WAIT_CYCLES = 2,
    parameter int DEPTH_WORDS = 256
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      start_i,
    input  core_pkg::mem_op_e         op_i,
    input  logic [core_pkg::XLEN-1:0] addr_i,
    input  logic [core_pkg::XLEN-1:0] store_data_i,
    output logic [core_pkg::XLEN-1:0] result_o,
    output logic                      done_o
);

    dmem_if dmem_bus ();

    load_store_unit i_lsu (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (start_i),
        .op_i         (op_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .result_o     (result_o),
        .done_o       (done_o),
        .mem          (dmem_bus.lsu)
    );

    // Fixed wait states stand in for the L1 cache
    data_mem #(
        .WAIT_CYCLES (WAIT_CYCLES),
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_dmem (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bus   (dmem_bus.mem)
    );

endmodule

// File: test/mem_stage_props.sv
// Concurrent assertions on the load/store unit, with their bind to every instance
module mem_stage_props (
    input logic                               clk_i,
    input logic                               rst_i,
    input logic                               start_i,
    input logic                               done_i,
    input logic                               sel_i,
    input logic                               wen_i,
    input logic [mem_pkg::BYTES_PER_WORD-1:0] mask_i
);

    // A write is only ever part of an active request
    a_wen_needs_sel: assert property (@(posedge clk_i) disable iff (rst_i)
        wen_i |-> sel_i)
        else $error("Write enable seen without an active request");

    // Single byte, aligned half or whole word
    a_mask_legal: assert property (@(posedge clk_i) disable iff (rst_i)
        sel_i |-> (mask_i inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                  4'b0011, 4'b1100, 4'b1111}))
        else $error("Illegal byte mask %b during a request", mask_i);

    a_done_needs_start: assert property (@(posedge clk_i) disable iff (rst_i)
        done_i |-> start_i)
        else $error("Done raised without a pending start");

endmodule

bind load_store_unit mem_stage_props i_props (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (start_i),
    .done_i  (done_o),
    .sel_i   (mem.sel),
    .wen_i   (mem.wen),
    .mask_i  (mem.mask)
);

// File: test/mem_stage_tb.sv
// Memory stage testbench with directed and random loads and stores against a byte model
module mem_stage_tb;

    localparam int          WAIT_CYCLES  = 3;
    localparam int          DEPTH_WORDS  = 256;
    localparam int          CLK_PERIOD   = 20;
    localparam int          DRIVE_DLY    = 2;
    localparam int          RESET_CYCLES = 3;
    localparam logic [31:0] BASE_ADDR    = 32'h0000_0180;
    localparam int          WIN_WORDS    = 16; // Small window so that accesses collide
    localparam int          WIN_BYTES    = WIN_WORDS * 4;
    localparam int          N_DIRECTED   = 62;
    localparam int          N_RANDOM     = 400;
    // Each request takes WAIT_CYCLES+1 cycles, plus at most one idle cycle before it
    localparam int          CYCLE_LIMIT  = (N_DIRECTED + N_RANDOM) * (WAIT_CYCLES + 2)
                                           + RESET_CYCLES + 100;

    logic                      clk;
    logic                      rst;
    logic                      start;
    core_pkg::mem_op_e         op;
    logic [core_pkg::XLEN-1:0] addr;
    logic [core_pkg::XLEN-1:0] store_data;
    logic [core_pkg::XLEN-1:0] result;
    logic                      done;

    logic [7:0]  model_mem [WIN_BYTES];
    logic [31:0] seed;
    int          value_errs;
    int          latency_errs;
    int          other_errs;
    int          cycle_cnt;

    mem_stage_top #(
        .WAIT_CYCLES (WAIT_CYCLES),
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .start_i      (start),
        .op_i         (op),
        .addr_i       (addr),
        .store_data_i (store_data),
        .result_o     (result),
        .done_o       (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic is_store_op(core_pkg::mem_op_e req_op);
        return req_op inside {core_pkg::SB, core_pkg::SH, core_pkg::SW};
    endfunction

    // Little endian view of the byte model, extended by the load rules
    function automatic logic [31:0] model_load(core_pkg::mem_op_e req_op, logic [31:0] req_addr);
        int i;
        i = int'(req_addr - BASE_ADDR);
        case (req_op)
            core_pkg::LB:  return {{24{model_mem[i][7]}}, model_mem[i]};
            core_pkg::LBU: return {24'h0, model_mem[i]};
            core_pkg::LH:  return {{16{model_mem[i+1][7]}}, model_mem[i+1], model_mem[i]};
            core_pkg::LHU: return {16'h0, model_mem[i+1], model_mem[i]};
            default:       return {model_mem[i+3], model_mem[i+2], model_mem[i+1], model_mem[i]};
        endcase
    endfunction

    function automatic void model_store(core_pkg::mem_op_e req_op, logic [31:0] req_addr,
                                        logic [31:0] data);
        int i;
        i = int'(req_addr - BASE_ADDR);
        model_mem[i] = data[7:0];
        if (req_op != core_pkg::SB) begin
            model_mem[i+1] = data[15:8];
        end
        if (req_op == core_pkg::SW) begin
            model_mem[i+2] = data[23:16];
            model_mem[i+3] = data[31:24];
        end
    endfunction

    // Random address in the window, aligned to the access size
    function automatic logic [31:0] rand_addr(core_pkg::mem_op_e req_op);
        logic [31:0] off;
        off = (next_rand() >> 16) % WIN_BYTES;
        if (req_op inside {core_pkg::LH, core_pkg::LHU, core_pkg::SH}) off[0] = 1'b0;
        if (req_op inside {core_pkg::LW, core_pkg::SW}) off[1:0] = 2'b00;
        return BASE_ADDR + off;
    endfunction

    task automatic check_result(string name, core_pkg::mem_op_e req_op,
                                logic [core_pkg::XLEN-1:0] expected,
                                logic [core_pkg::XLEN-1:0] actual);
        if (actual !== expected) begin
            value_errs++;
            $display("FAIL %s (%s): expected %08h actual %08h", name, req_op.name(),
                     expected, actual);
        end
    endtask

    task automatic check_latency(string name, int expected, int actual);
        if (actual != expected) begin
            latency_errs++;
            $display("FAIL %s latency: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // Holds one request until done_o, then checks latency and the load result
    task automatic do_request(string name, core_pkg::mem_op_e req_op, logic [31:0] req_addr,
                              logic [31:0] req_data);
        int          waited;
        logic [31:0] expected;
        waited = 0;
        @(posedge clk);
        #DRIVE_DLY;
        start      = 1'b1;
        op         = req_op;
        addr       = req_addr;
        store_data = req_data;
        expected   = model_load(req_op, req_addr);
        @(negedge clk); // Cycle 0 of the request
        while (!done && waited < WAIT_CYCLES + 1) begin
            waited++;
            @(negedge clk);
        end
        if (!done) begin
            other_errs++;
            $display("ERROR %s: done_o did not rise within %0d cycles of start_i", name,
                     WAIT_CYCLES + 1);
        end else begin
            check_latency(name, WAIT_CYCLES, waited);
            if (is_store_op(req_op)) begin
                model_store(req_op, req_addr, req_data);
            end else begin
                check_result(name, req_op, expected, result);
            end
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        start = 1'b0;
        @(negedge clk);
        if (done) begin
            other_errs++;
            $display("ERROR: done_o is high in a cycle without start_i");
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            other_errs++;
            $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors: value %0d, latency %0d, other %0d", value_errs, latency_errs,
                     other_errs);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0]       r;
        core_pkg::mem_op_e rop;
        seed         = 32'h35037ce2;
        value_errs   = 0;
        latency_errs = 0;
        other_errs   = 0;
        cycle_cnt    = 0;
        rst          = 1'b1;
        start        = 1'b0;
        op           = core_pkg::LW;
        addr         = BASE_ADDR;
        store_data   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        idle_cycle();

        // Fill the whole window so that every later load has known data
        for (int w = 0; w < WIN_WORDS; w++) begin
            do_request("sw_fill", core_pkg::SW, BASE_ADDR + 4 * w, next_rand());
        end
        for (int w = 0; w < WIN_WORDS; w++) begin
            do_request("lw_readback", core_pkg::LW, BASE_ADDR + 4 * w, '0);
        end

        for (int b = 0; b < 4; b++) begin
            do_request("sb_lane", core_pkg::SB, BASE_ADDR + b, next_rand());
            do_request("sb_lane_word", core_pkg::LW, BASE_ADDR, '0);
        end

        // Bytes with the top bit both set and clear
        do_request("lb_setup", core_pkg::SW, BASE_ADDR + 4, 32'h7f80_01fe);
        for (int b = 0; b < 4; b++) begin
            do_request("lb_offset", core_pkg::LB, BASE_ADDR + 4 + b, '0);
            do_request("lbu_offset", core_pkg::LBU, BASE_ADDR + 4 + b, '0);
        end

        do_request("lh_setup", core_pkg::SW, BASE_ADDR + 8, 32'h8001_7ffe);
        for (int h = 0; h < 4; h += 2) begin
            do_request("lh_offset", core_pkg::LH, BASE_ADDR + 8 + h, '0);
            do_request("lhu_offset", core_pkg::LHU, BASE_ADDR + 8 + h, '0);
        end
        for (int h = 0; h < 4; h += 2) begin
            do_request("sh_lane", core_pkg::SH, BASE_ADDR + 12 + h, next_rand());
            do_request("sh_lane_word", core_pkg::LW, BASE_ADDR + 12, '0);
        end
        for (int h = 0; h < 4; h += 2) begin
            do_request("sh_lh", core_pkg::LH, BASE_ADDR + 12 + h, '0);
            do_request("sh_lhu", core_pkg::LHU, BASE_ADDR + 12 + h, '0);
        end

        // Mostly back to back, with an idle gap now and then
        for (int n = 0; n < N_RANDOM; n++) begin
            r = next_rand();
            if (r[29:28] == 2'b00) idle_cycle();
            rop = core_pkg::mem_op_e'(r[18:16]);
            do_request("random_mix", rop, rand_addr(rop), next_rand());
        end
        idle_cycle();

        $display("Errors: value %0d, latency %0d, other %0d", value_errs, latency_errs,
                 other_errs);
        if (value_errs + latency_errs + other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
hw/core_pkg.sv
hw/mem_pkg.sv
hw/dmem_if.sv
hw/load_store_unit.sv
hw/data_mem.sv
hw/mem_stage_top.sv
test/mem_stage_props.sv
test/mem_stage_tb.sv

// File: run.sh
#!/bin/sh
# Builds the memory stage testbench with Verilator, runs it and scans the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mem_stage_tb -f list.f \
    && ./obj_dir/Vmem_stage_tb > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "RESULT: FAIL" sim.log \
    && echo "Simulation passed" \
    || { cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }
